//--- all.f
mac_ctrl_pkg.sv
mcf_rx_parser.sv
pause_quanta_timer.sv
pause_stat_collector.sv
eth_mac_pause_rx.sv
tb_clock_gen.sv
tb_eth_mac_pause_rx.sv

//--- Makefile
TOP := tb_eth_mac_pause_rx

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- tb_eth_mac_pause_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_pause_rx;

    import mac_ctrl_pkg::*;

    localparam int rand_seed       = 72973;
    localparam int preamble_bytes  = 7;
    localparam int gap_bytes       = 12;
    localparam int frame_bytes_max = 128;
    localparam int max_quanta      = 40;
    localparam int frames_total    = 14;
    localparam int tests_total     = 5;
    localparam int slot_cycles     = preamble_bytes + 1 + min_frame_bytes + gap_bytes;
    localparam int test_cycles     = max_quanta * 64 + 20;   // Longest pause and settling.
    localparam int watchdog_cycles =
        2 * (20 + frames_total * slot_cycles + tests_total * test_cycles);

    // What one received frame should do to the outputs.
    typedef struct packed {
        logic                         accept;
        mcf_kind_t                    kind;
        logic [num_prio-1:0]          load;
        logic [num_prio*quanta_w-1:0] quanta;
    } effect_t;

    logic                gmii_gtx_clk;
    logic                gmii_rx_rst;
    logic [7:0]          gmii_rxd;
    logic                gmii_rx_dv;
    logic                gmii_rx_er;
    logic                cfg_rx_lfc_en;
    logic [num_prio-1:0] cfg_rx_pfc_en;
    logic [num_prio-1:0] rx_pause_req;
    logic                stat_rx_lfc_pkt;
    logic                stat_rx_pfc_pkt;
    logic [num_prio-1:0] stat_rx_xoff;
    logic [num_prio-1:0] stat_rx_xon;
    logic [15:0]         lfc_pkt_count;
    logic [15:0]         pfc_pkt_count;

    logic [7:0] frame_buf [frame_bytes_max];   // Bytes after the SFD, FCS included.
    int         frame_len;

    // Expected state, advanced on every falling edge.
    effect_t             exp_eff [$];
    int                  exp_cycle [$];
    int                  remaining [num_prio];
    logic [num_prio-1:0] exp_req;
    logic [num_prio-1:0] exp_xoff;
    logic [num_prio-1:0] exp_xon;
    logic                exp_lfc_pkt;
    logic                exp_pfc_pkt;
    logic [15:0]         exp_lfc_count;
    logic [15:0]         exp_pfc_count;

    int    cyc = 0;
    string test_name = "reset";
    int    errors = 0;
    int    test_start_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    tb_clock_gen i_tb_clock_gen (
        .gmii_gtx_clk (gmii_gtx_clk),
        .gmii_rx_rst  (gmii_rx_rst)
    );

    eth_mac_pause_rx i_eth_mac_pause_rx (
        .gmii_gtx_clk    (gmii_gtx_clk),
        .gmii_rx_rst     (gmii_rx_rst),
        .gmii_rxd        (gmii_rxd),
        .gmii_rx_dv      (gmii_rx_dv),
        .gmii_rx_er      (gmii_rx_er),
        .cfg_rx_lfc_en   (cfg_rx_lfc_en),
        .cfg_rx_pfc_en   (cfg_rx_pfc_en),
        .rx_pause_req    (rx_pause_req),
        .stat_rx_lfc_pkt (stat_rx_lfc_pkt),
        .stat_rx_pfc_pkt (stat_rx_pfc_pkt),
        .stat_rx_xoff    (stat_rx_xoff),
        .stat_rx_xon     (stat_rx_xon),
        .lfc_pkt_count   (lfc_pkt_count),
        .pfc_pkt_count   (pfc_pkt_count)
    );

    always @(posedge gmii_gtx_clk) begin
        cyc <= cyc + 1;
    end

    // Frame rules of 802.3 annex 31B and 802.1Qbb.
    function automatic effect_t expected_effect(input logic [7:0] bytes [frame_bytes_max],
                                                input int len, input bit had_er,
                                                input logic lfc_en,
                                                input logic [num_prio-1:0] pfc_en);
        effect_t     eff;
        logic [47:0] dst;
        logic [15:0] etype;
        logic [15:0] opcode;
        logic [15:0] param;
        bit          frame_ok;
        eff    = '0;
        dst    = {bytes[0], bytes[1], bytes[2], bytes[3], bytes[4], bytes[5]};
        etype  = {bytes[12], bytes[13]};
        opcode = {bytes[14], bytes[15]};
        param  = {bytes[16], bytes[17]};
        frame_ok = !had_er && (len >= min_frame_bytes) && (dst == mcf_dst_addr) &&
                   (etype == mcf_eth_type);
        eff.kind = mcf_none;
        if (frame_ok && opcode == opcode_lfc && lfc_en) begin
            eff.accept = 1'b1;
            eff.kind   = mcf_lfc;
            eff.load   = '1;
            for (int i = 0; i < num_prio; i++) begin
                eff.quanta[i*quanta_w +: quanta_w] = param;
            end
        end else if (frame_ok && opcode == opcode_pfc && pfc_en != '0) begin
            eff.accept = 1'b1;
            eff.kind   = mcf_pfc;
            eff.load   = param[num_prio-1:0] & pfc_en;
            for (int i = 0; i < num_prio; i++) begin
                eff.quanta[i*quanta_w +: quanta_w] = {bytes[18 + 2*i], bytes[19 + 2*i]};
            end
        end
        return eff;
    endfunction

    task automatic report_mismatch(input string what, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic check_value(input string what, input logic [15:0] exp,
                               input logic [15:0] act);
        assert (act === exp) else report_mismatch(what, exp, act);
    endtask

    // Outputs follow the end of frame by 3 cycles, counters by 2.
    task automatic advance_model();
        effect_t     eff;
        logic [15:0] qv;
        exp_xoff    = '0;
        exp_xon     = '0;
        exp_lfc_pkt = 1'b0;
        exp_pfc_pkt = 1'b0;
        for (int i = 0; i < num_prio; i++) begin
            if (remaining[i] > 0) remaining[i]--;
        end
        if (exp_cycle.size() > 0) begin
            eff = exp_eff[0];
            if (cyc == exp_cycle[0] + 2 && eff.accept) begin
                if (eff.kind == mcf_lfc) exp_lfc_count++;
                else exp_pfc_count++;
            end
            if (cyc == exp_cycle[0] + 3) begin
                exp_lfc_pkt = eff.accept && (eff.kind == mcf_lfc);
                exp_pfc_pkt = eff.accept && (eff.kind == mcf_pfc);
                for (int i = 0; i < num_prio; i++) begin
                    qv = eff.quanta[i*quanta_w +: quanta_w];
                    if (eff.accept && eff.load[i]) begin
                        remaining[i] = 64 * int'(qv);   // 512 bit times per quantum.
                        exp_xoff[i]  = (qv != '0);
                        exp_xon[i]   = (qv == '0);
                    end
                end
                void'(exp_eff.pop_front());
                void'(exp_cycle.pop_front());
            end
        end
        for (int i = 0; i < num_prio; i++) begin
            exp_req[i] = (remaining[i] > 0);
        end
    endtask

    task automatic check_outputs();
        check_value("rx_pause_req", 16'(exp_req), 16'(rx_pause_req));
        check_value("stat_rx_xoff", 16'(exp_xoff), 16'(stat_rx_xoff));
        check_value("stat_rx_xon", 16'(exp_xon), 16'(stat_rx_xon));
        check_value("stat_rx_lfc_pkt", 16'(exp_lfc_pkt), 16'(stat_rx_lfc_pkt));
        check_value("stat_rx_pfc_pkt", 16'(exp_pfc_pkt), 16'(stat_rx_pfc_pkt));
        check_value("lfc_pkt_count", exp_lfc_count, lfc_pkt_count);
        check_value("pfc_pkt_count", exp_pfc_count, pfc_pkt_count);
    endtask

    // Compare every cycle, once outputs have settled.
    always @(negedge gmii_gtx_clk) begin
        if (gmii_rx_rst) begin
            for (int i = 0; i < num_prio; i++) remaining[i] = 0;
            exp_req       = '0;
            exp_lfc_count = '0;
            exp_pfc_count = '0;
        end else begin
            advance_model();
            check_outputs();
        end
    end

    task automatic drive_byte(input logic [7:0] b, input logic dv, input logic er);
        @(negedge gmii_gtx_clk);
        gmii_rxd   = b;
        gmii_rx_dv = dv;
        gmii_rx_er = er;
    endtask

    task automatic put16(input int offset, input logic [15:0] value);
        frame_buf[offset]     = value[15:8];
        frame_buf[offset + 1] = value[7:0];
    endtask

    task automatic build_frame(input logic [47:0] dst, input logic [15:0] etype,
                               input logic [15:0] opcode, input int len);
        for (int i = 0; i < frame_bytes_max; i++) frame_buf[i] = 8'($urandom);  // Padding.
        for (int i = 0; i < 6; i++) frame_buf[i] = dst[47 - 8*i -: 8];
        for (int i = 0; i < 6; i++) frame_buf[6 + i] = (i == 0) ? 8'h02 : 8'(i);
        put16(12, etype);
        put16(14, opcode);
        frame_len = len;
    endtask

    function automatic logic [15:0] random_quanta(input int lo, input int hi);
        return 16'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    task automatic build_pfc(input logic [7:0] ce, input int lo, input int hi);
        build_frame(mcf_dst_addr, mcf_eth_type, opcode_pfc, min_frame_bytes);
        put16(16, {8'h00, ce});
        for (int i = 0; i < num_prio; i++) put16(18 + 2*i, random_quanta(lo, hi));
    endtask

    // Preamble, SFD, frame with FCS, then the inter-frame gap.
    task automatic send_frame(input int er_at);
        for (int i = 0; i < preamble_bytes; i++) drive_byte(8'h55, 1'b1, 1'b0);
        drive_byte(sfd_byte, 1'b1, 1'b0);
        for (int i = 0; i < frame_len; i++) drive_byte(frame_buf[i], 1'b1, i == er_at);
        drive_byte(8'h00, 1'b0, 1'b0);
        exp_cycle.push_back(cyc);
        exp_eff.push_back(expected_effect(frame_buf, frame_len, er_at >= 0 && er_at < frame_len,
                                          cfg_rx_lfc_en, cfg_rx_pfc_en));
        repeat (gap_bytes - 1) @(negedge gmii_gtx_clk);
    endtask

    task automatic wait_idle();
        @(negedge gmii_gtx_clk);
        while (exp_cycle.size() != 0 || exp_req != '0 || rx_pause_req != '0) begin
            @(negedge gmii_gtx_clk);
        end
        repeat (4) @(negedge gmii_gtx_clk);
    endtask

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        int n;
        n = errors - test_start_errors;
        tests_run++;
        if (n == 0) begin
            $display("Test %s: PASS", test_name);
        end else begin
            $display("Test %s: FAIL with %0d errors", test_name, n);
            tests_failed++;
        end
    endtask

    initial begin
        logic [15:0] q;
        logic [15:0] lfc_before;
        logic [15:0] pfc_before;
        void'($urandom(rand_seed));
        gmii_rxd      = '0;
        gmii_rx_dv    = 1'b0;
        gmii_rx_er    = 1'b0;
        cfg_rx_lfc_en = 1'b1;
        cfg_rx_pfc_en = '1;
        @(negedge gmii_gtx_clk);
        wait (!gmii_rx_rst);
        repeat (4) @(negedge gmii_gtx_clk);

        start_test("lfc_pause");
        lfc_before = lfc_pkt_count;
        build_frame(mcf_dst_addr, mcf_eth_type, opcode_lfc, min_frame_bytes);
        put16(16, random_quanta(1, max_quanta));
        send_frame(-1);
        wait_idle();
        check_value("lfc_pkt_count", lfc_before + 16'd1, lfc_pkt_count);
        finish_test();

        start_test("pfc_random");
        for (int f = 0; f < 2; f++) begin
            build_pfc(8'($urandom) | (8'h01 << ($urandom % 8)), 1, max_quanta);
            send_frame(-1);
            wait_idle();
        end
        finish_test();

        start_test("pfc_xon");
        build_pfc(8'hFF, 10, 30);
        send_frame(-1);
        build_pfc(8'($urandom) | 8'h01, 0, 0);   // Zero quanta releases.
        send_frame(-1);
        wait_idle();
        finish_test();

        start_test("rejected_frames");
        lfc_before = lfc_pkt_count;
        pfc_before = pfc_pkt_count;
        q = random_quanta(1, max_quanta);
        build_frame(mcf_dst_addr ^ 48'h1, mcf_eth_type, opcode_lfc, min_frame_bytes);
        put16(16, q);
        send_frame(-1);
        build_frame(mcf_dst_addr, 16'h0800, opcode_lfc, min_frame_bytes);
        put16(16, q);
        send_frame(-1);
        build_frame(mcf_dst_addr, mcf_eth_type, opcode_lfc, min_frame_bytes);
        put16(16, q);
        send_frame(20);
        build_frame(mcf_dst_addr, mcf_eth_type, opcode_lfc, 44);   // Runt.
        put16(16, q);
        send_frame(-1);
        cfg_rx_lfc_en = 1'b0;
        build_frame(mcf_dst_addr, mcf_eth_type, opcode_lfc, min_frame_bytes);
        put16(16, q);
        send_frame(-1);
        cfg_rx_lfc_en = 1'b1;
        cfg_rx_pfc_en = '0;
        build_pfc(8'hFF, 1, max_quanta);
        send_frame(-1);
        cfg_rx_pfc_en = '1;
        wait_idle();
        check_value("lfc_pkt_count", lfc_before, lfc_pkt_count);
        check_value("pfc_pkt_count", pfc_before, pfc_pkt_count);
        finish_test();

        start_test("back_to_back");
        pfc_before = pfc_pkt_count;
        for (int f = 0; f < 3; f++) begin
            build_pfc(8'($urandom) | 8'h01, 20, max_quanta);   // Outlasts one frame slot.
            send_frame(-1);
        end
        wait_idle();
        check_value("pfc_pkt_count", pfc_before + 16'd3, pfc_pkt_count);
        finish_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_run == tests_total) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge gmii_gtx_clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic gmii_gtx_clk,
    output logic gmii_rx_rst
);

    localparam int half_period  = 50;   // 100 ns period.
    localparam int reset_cycles = 10;

    initial begin
        gmii_gtx_clk = 1'b0;
        forever #half_period gmii_gtx_clk = ~gmii_gtx_clk;
    end

    // Release on a falling edge, clear of the sampling edge.
    initial begin
        gmii_rx_rst = 1'b1;
        repeat (reset_cycles) @(posedge gmii_gtx_clk);
        @(negedge gmii_gtx_clk);
        gmii_rx_rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- eth_mac_pause_rx.sv
`timescale 1ns/1ps
`default_nettype none

module eth_mac_pause_rx (
    input  wire                                   gmii_gtx_clk,
    input  wire                                   gmii_rx_rst,
    input  wire [mac_ctrl_pkg::gmii_w-1:0]        gmii_rxd,
    input  wire                                   gmii_rx_dv,
    input  wire                                   gmii_rx_er,
    input  wire                                   cfg_rx_lfc_en,
    input  wire [mac_ctrl_pkg::num_prio-1:0]      cfg_rx_pfc_en,
    output logic [mac_ctrl_pkg::num_prio-1:0]     rx_pause_req,
    output logic                                  stat_rx_lfc_pkt,
    output logic                                  stat_rx_pfc_pkt,
    output logic [mac_ctrl_pkg::num_prio-1:0]     stat_rx_xoff,
    output logic [mac_ctrl_pkg::num_prio-1:0]     stat_rx_xon,
    output logic [mac_ctrl_pkg::stat_cnt_w-1:0]   lfc_pkt_count,
    output logic [mac_ctrl_pkg::stat_cnt_w-1:0]   pfc_pkt_count
);

    import mac_ctrl_pkg::*;

    logic                         mcf_valid;
    mcf_kind_t                    mcf_kind;
    logic [num_prio-1:0]          pause_load;
    logic [num_prio*quanta_w-1:0] pause_quanta;
    logic [num_prio-1:0]          paused;
    logic [num_prio-1:0]          xoff_event;
    logic [num_prio-1:0]          xon_event;

    mcf_rx_parser i_mcf_rx_parser (
        .gmii_gtx_clk  (gmii_gtx_clk),
        .gmii_rx_rst   (gmii_rx_rst),
        .gmii_rxd      (gmii_rxd),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rx_er    (gmii_rx_er),
        .cfg_rx_lfc_en (cfg_rx_lfc_en),
        .cfg_rx_pfc_en (cfg_rx_pfc_en),
        .mcf_valid     (mcf_valid),
        .mcf_kind      (mcf_kind),
        .pause_load    (pause_load),
        .pause_quanta  (pause_quanta)
    );

    // One countdown per priority.
    for (genvar i = 0; i < num_prio; i++) begin : g_timer
        pause_quanta_timer i_pause_quanta_timer (
            .gmii_gtx_clk (gmii_gtx_clk),
            .gmii_rx_rst  (gmii_rx_rst),
            .load         (mcf_valid && pause_load[i]),
            .quanta       (pause_quanta[i*quanta_w +: quanta_w]),
            .paused       (paused[i]),
            .xoff_event   (xoff_event[i]),
            .xon_event    (xon_event[i])
        );
    end

    pause_stat_collector i_pause_stat_collector (
        .gmii_gtx_clk    (gmii_gtx_clk),
        .gmii_rx_rst     (gmii_rx_rst),
        .mcf_valid       (mcf_valid),
        .mcf_kind        (mcf_kind),
        .paused          (paused),
        .xoff_event      (xoff_event),
        .xon_event       (xon_event),
        .rx_pause_req    (rx_pause_req),
        .stat_rx_lfc_pkt (stat_rx_lfc_pkt),
        .stat_rx_pfc_pkt (stat_rx_pfc_pkt),
        .stat_rx_xoff    (stat_rx_xoff),
        .stat_rx_xon     (stat_rx_xon),
        .lfc_pkt_count   (lfc_pkt_count),
        .pfc_pkt_count   (pfc_pkt_count)
    );

endmodule

`default_nettype wire

//--- pause_stat_collector.sv
`timescale 1ns/1ps
`default_nettype none

module pause_stat_collector (
    input  wire                                   gmii_gtx_clk,
    input  wire                                   gmii_rx_rst,
    input  wire                                   mcf_valid,
    input  wire mac_ctrl_pkg::mcf_kind_t          mcf_kind,
    input  wire [mac_ctrl_pkg::num_prio-1:0]      paused,
    input  wire [mac_ctrl_pkg::num_prio-1:0]      xoff_event,
    input  wire [mac_ctrl_pkg::num_prio-1:0]      xon_event,
    output logic [mac_ctrl_pkg::num_prio-1:0]     rx_pause_req,
    output logic                                  stat_rx_lfc_pkt,
    output logic                                  stat_rx_pfc_pkt,
    output logic [mac_ctrl_pkg::num_prio-1:0]     stat_rx_xoff,
    output logic [mac_ctrl_pkg::num_prio-1:0]     stat_rx_xon,
    output logic [mac_ctrl_pkg::stat_cnt_w-1:0]   lfc_pkt_count,
    output logic [mac_ctrl_pkg::stat_cnt_w-1:0]   pfc_pkt_count
);

    import mac_ctrl_pkg::*;

    // Frame strobe delayed to line up with the timer events.
    logic      pkt_valid_d;
    mcf_kind_t pkt_kind_d;

    always_ff @(posedge gmii_gtx_clk or posedge gmii_rx_rst) begin
        if (gmii_rx_rst) begin
            rx_pause_req    <= '0;
            stat_rx_xoff    <= '0;
            stat_rx_xon     <= '0;
            pkt_valid_d     <= 1'b0;
            pkt_kind_d      <= mcf_none;
            stat_rx_lfc_pkt <= 1'b0;
            stat_rx_pfc_pkt <= 1'b0;
            lfc_pkt_count   <= '0;
            pfc_pkt_count   <= '0;
        end else begin
            rx_pause_req <= paused;
            stat_rx_xoff <= xoff_event;
            stat_rx_xon  <= xon_event;

            pkt_valid_d     <= mcf_valid;
            pkt_kind_d      <= mcf_kind;
            stat_rx_lfc_pkt <= pkt_valid_d && (pkt_kind_d == mcf_lfc);
            stat_rx_pfc_pkt <= pkt_valid_d && (pkt_kind_d == mcf_pfc);

            // Counters wrap.
            if (mcf_valid && mcf_kind == mcf_lfc) begin
                lfc_pkt_count <= lfc_pkt_count + 1'b1;
            end
            if (mcf_valid && mcf_kind == mcf_pfc) begin
                pfc_pkt_count <= pfc_pkt_count + 1'b1;
            end
        end
    end

    // Every accepted frame carries a known kind from the parser.
    assert property (@(posedge gmii_gtx_clk) disable iff (gmii_rx_rst)
        mcf_valid |-> ##2 (stat_rx_lfc_pkt || stat_rx_pfc_pkt));

endmodule

`default_nettype wire

//--- pause_quanta_timer.sv
`timescale 1ns/1ps
`default_nettype none

module pause_quanta_timer (
    input  wire                                gmii_gtx_clk,
    input  wire                                gmii_rx_rst,
    input  wire                                load,
    input  wire [mac_ctrl_pkg::quanta_w-1:0]   quanta,
    output logic                               paused,
    output logic                               xoff_event,
    output logic                               xon_event
);

    import mac_ctrl_pkg::*;

    logic [timer_w-1:0] count;   // Remaining pause in 1/256 quanta.

    assign paused = (count != '0);

    always_ff @(posedge gmii_gtx_clk or posedge gmii_rx_rst) begin
        if (gmii_rx_rst) begin
            count      <= '0;
            xoff_event <= 1'b0;
            xon_event  <= 1'b0;
        end else begin
            xoff_event <= 1'b0;
            xon_event  <= 1'b0;
            if (load) begin
                // New frame restarts the count.
                count      <= timer_w'({quanta, 8'h00});
                xoff_event <= (quanta != '0);
                xon_event  <= (quanta == '0); // Zero quanta is XON.
            end else if (count > timer_w'(quanta_step)) begin
                count <= count - timer_w'(quanta_step);
            end else begin
                count <= '0;
            end
        end
    end

    assert property (@(posedge gmii_gtx_clk) disable iff (gmii_rx_rst)
        !(xoff_event && xon_event));

endmodule

`default_nettype wire

//--- mcf_rx_parser.sv
`timescale 1ns/1ps
`default_nettype none

module mcf_rx_parser (
    input  wire                                                  gmii_gtx_clk,
    input  wire                                                  gmii_rx_rst,
    input  wire [mac_ctrl_pkg::gmii_w-1:0]                       gmii_rxd,
    input  wire                                                  gmii_rx_dv,
    input  wire                                                  gmii_rx_er,
    input  wire                                                  cfg_rx_lfc_en,
    input  wire [mac_ctrl_pkg::num_prio-1:0]                     cfg_rx_pfc_en,
    output logic                                                 mcf_valid,
    output mac_ctrl_pkg::mcf_kind_t                              mcf_kind,
    output logic [mac_ctrl_pkg::num_prio-1:0]                    pause_load,
    output logic [mac_ctrl_pkg::num_prio*mac_ctrl_pkg::quanta_w-1:0] pause_quanta
);

    import mac_ctrl_pkg::*;

    parse_state_t                      state;
    logic [$clog2(min_frame_bytes):0]  byte_cnt;   // Saturates at all ones.

    // Captured header fields.
    logic [47:0]         dst_reg;
    logic [15:0]         type_reg;
    logic [15:0]         opcode_reg;
    logic [15:0]         param_reg;
    logic [quanta_w-1:0] quanta_reg [num_prio];

    logic              frame_end;
    logic              capture;
    logic              in_quanta;
    logic [prio_w-1:0] q_idx;
    logic              hdr_ok;
    logic              lfc_hit;
    logic              pfc_hit;

    assign frame_end = (state == st_frame) && !gmii_rx_dv;
    assign capture   = (state == st_frame) && gmii_rx_dv;

    // PFC quanta field i sits at two bytes per priority.
    assign in_quanta = (byte_cnt >= pfc_quanta_offset) &&
                       (byte_cnt < pfc_quanta_offset + 2 * num_prio);
    assign q_idx     = prio_w'((byte_cnt - pfc_quanta_offset) >> 1);

    always_comb begin
        hdr_ok  = (dst_reg == mcf_dst_addr) && (type_reg == mcf_eth_type) &&
                  (byte_cnt >= min_frame_bytes);
        lfc_hit = hdr_ok && (opcode_reg == opcode_lfc) && cfg_rx_lfc_en;
        pfc_hit = hdr_ok && (opcode_reg == opcode_pfc) && (cfg_rx_pfc_en != '0);
    end

    always_ff @(posedge gmii_gtx_clk or posedge gmii_rx_rst) begin
        if (gmii_rx_rst) begin
            state      <= st_idle;
            byte_cnt   <= '0;
            mcf_valid  <= 1'b0;
            mcf_kind   <= mcf_none;
            pause_load <= '0;
        end else begin
            mcf_valid <= 1'b0;
            case (state)
                st_idle, st_preamble: begin
                    if (!gmii_rx_dv) begin
                        state <= st_idle;
                    end else if (gmii_rx_er) begin
                        state <= st_drop;
                    end else if (gmii_rxd == sfd_byte) begin
                        state    <= st_frame;
                        byte_cnt <= '0;
                    end else begin
                        state <= st_preamble;
                    end
                end
                st_frame: begin
                    if (!gmii_rx_dv) begin
                        // End of frame, judge it.
                        state     <= st_idle;
                        mcf_valid <= lfc_hit || pfc_hit;
                        if (lfc_hit) begin
                            mcf_kind   <= mcf_lfc;
                            pause_load <= '1; // LFC pauses every priority.
                        end else if (pfc_hit) begin
                            mcf_kind   <= mcf_pfc;
                            pause_load <= param_reg[num_prio-1:0] & cfg_rx_pfc_en;
                        end else begin
                            mcf_kind   <= mcf_none;
                            pause_load <= '0;
                        end
                    end else if (gmii_rx_er) begin
                        state <= st_drop;
                    end else if (byte_cnt != '1) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                st_drop: begin
                    if (!gmii_rx_dv) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Field capture and quanta output.
    always_ff @(posedge gmii_gtx_clk) begin
        if (capture) begin
            if (byte_cnt < dst_bytes) begin
                dst_reg <= {dst_reg[39:0], gmii_rxd};
            end
            if (byte_cnt == type_offset || byte_cnt == type_offset + 1) begin
                type_reg <= {type_reg[7:0], gmii_rxd};
            end
            if (byte_cnt == opcode_offset || byte_cnt == opcode_offset + 1) begin
                opcode_reg <= {opcode_reg[7:0], gmii_rxd};
            end
            if (byte_cnt == param_offset || byte_cnt == param_offset + 1) begin
                param_reg <= {param_reg[7:0], gmii_rxd};
            end
            if (in_quanta) begin
                quanta_reg[q_idx] <= {quanta_reg[q_idx][7:0], gmii_rxd}; // Big endian.
            end
        end
        if (frame_end) begin
            for (int i = 0; i < num_prio; i++) begin
                pause_quanta[i*quanta_w +: quanta_w] <=
                    (opcode_reg == opcode_lfc) ? param_reg : quanta_reg[i];
            end
        end
    end

    // One strobe per frame; frames are far longer than a cycle.
    assert property (@(posedge gmii_gtx_clk) disable iff (gmii_rx_rst)
        mcf_valid |=> !mcf_valid);

endmodule

`default_nettype wire

//--- mac_ctrl_pkg.sv
`default_nettype none

package mac_ctrl_pkg;

    // Datapath and timer sizes.
    localparam int num_prio    = 8;
    localparam int prio_w      = $clog2(num_prio);
    localparam int quanta_w    = 16;
    localparam int timer_w     = 24;      // Count in 1/256 quanta.
    localparam int quanta_step = 4;       // 8 bits per clock, 512 bit times per quantum.
    localparam int gmii_w      = 8;
    localparam int stat_cnt_w  = 16;

    // Frame constants.
    localparam logic [gmii_w-1:0] sfd_byte          = 8'hD5;
    localparam logic [15:0]       mcf_eth_type      = 16'h8808;
    localparam logic [47:0]       mcf_dst_addr      = 48'h0180_C200_0001;
    localparam logic [15:0]       opcode_lfc        = 16'h0001;
    localparam logic [15:0]       opcode_pfc        = 16'h0101;
    localparam int                min_frame_bytes   = 64; // Includes the FCS.

    // Byte offsets after the SFD.
    localparam int dst_bytes         = 6;
    localparam int type_offset       = 12;
    localparam int opcode_offset     = 14;
    localparam int param_offset      = 16; // LFC quanta or PFC class-enable vector.
    localparam int pfc_quanta_offset = 18;

    typedef enum logic [1:0] {
        mcf_none,
        mcf_lfc,
        mcf_pfc
    } mcf_kind_t;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_frame,
        st_drop
    } parse_state_t;

endpackage

`default_nettype wire
